// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	// ALU funct3 values
	// add and sub share one, as do srl and sra
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// ADDI x0,x0,0
	localparam instr_t nop_instr = 32'h0000_0013;

endpackage

// File: rtl/pipe_pkg.sv
package pipe_pkg;

	typedef logic [3:0] alu_op_t;

	localparam alu_op_t alu_add = 4'd0;
	localparam alu_op_t alu_sub = 4'd1;
	localparam alu_op_t alu_sll = 4'd2;
	localparam alu_op_t alu_slt = 4'd3;
	localparam alu_op_t alu_sltu = 4'd4;
	localparam alu_op_t alu_xor = 4'd5;
	localparam alu_op_t alu_srl = 4'd6;
	localparam alu_op_t alu_sra = 4'd7;
	localparam alu_op_t alu_or = 4'd8;
	localparam alu_op_t alu_and = 4'd9;

	localparam rv_isa_pkg::word_t reset_pc = 32'h0000_0000;

	// Decode to execute bundle
	typedef struct packed {
		logic valid;
		rv_isa_pkg::word_t pc;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::reg_addr_t rs1;
		rv_isa_pkg::reg_addr_t rs2;
		rv_isa_pkg::word_t rs1_val;
		rv_isa_pkg::word_t rs2_val;
		rv_isa_pkg::word_t imm;
		alu_op_t alu_op;
		logic use_imm;
		logic use_pc;
		logic zero_a;
		logic write_reg;
		logic mem_read;
		logic mem_write;
	} decoded_t;

	typedef struct packed {
		logic en;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::word_t data;
	} reg_write_t;

endpackage

// File: rtl/register_file.sv
`timescale 1ns/10ps

module register_file (
	input logic clk,
	input rv_isa_pkg::reg_addr_t rd_addr_a,
	input rv_isa_pkg::reg_addr_t rd_addr_b,
	output rv_isa_pkg::word_t rd_data_a,
	output rv_isa_pkg::word_t rd_data_b,
	input pipe_pkg::reg_write_t wb_write
);

	// x0 has no storage
	rv_isa_pkg::word_t regs [1:31];

	function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t addr);
		if (addr == '0) begin
			read_port = '0;
		end else if (wb_write.en && wb_write.rd == addr) begin
			read_port = wb_write.data;
		end else begin
			read_port = regs[addr];
		end
	endfunction

	always_ff @(posedge clk) begin
		if (wb_write.en && wb_write.rd != '0) begin
			regs[wb_write.rd] <= wb_write.data;
		end
	end

	// Write-back in the same cycle is seen by decode
	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
	end

endmodule

// File: rtl/fetch_decode.sv
`timescale 1ns/10ps

module fetch_decode (
	input logic clk,
	input logic reset,
	output rv_isa_pkg::word_t fetch_addr,
	input rv_isa_pkg::instr_t fetch_instr,
	output rv_isa_pkg::reg_addr_t rd_addr_a,
	output rv_isa_pkg::reg_addr_t rd_addr_b,
	input rv_isa_pkg::word_t rd_data_a,
	input rv_isa_pkg::word_t rd_data_b,
	output pipe_pkg::decoded_t id_ex
);

	rv_isa_pkg::word_t pc;
	logic if_valid;
	rv_isa_pkg::word_t if_pc;
	rv_isa_pkg::instr_t if_instr;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;
	pipe_pkg::alu_op_t alu_op;
	rv_isa_pkg::word_t imm_i;
	rv_isa_pkg::word_t imm_s;
	rv_isa_pkg::word_t imm_u;
	pipe_pkg::decoded_t dec;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= pipe_pkg::reset_pc;
			if_valid <= 1'b0;
		end else begin
			pc <= pc + 32'd4;
			if_valid <= 1'b1;
		end
		if_pc <= pc;
		if_instr <= fetch_instr;
	end

	assign fetch_addr = pc;

	assign opcode = if_instr[6:0];
	assign funct3 = if_instr[14:12];
	assign alt = if_instr[30];
	assign rd_addr_a = if_instr[19:15];
	assign rd_addr_b = if_instr[24:20];

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_u = {if_instr[31:12], 12'b0};

	// Loads, stores and upper immediates all add
	always_comb begin
		alu_op = pipe_pkg::alu_add;
		if (opcode == rv_isa_pkg::op_reg || opcode == rv_isa_pkg::op_imm) begin
			case (funct3)
				rv_isa_pkg::f3_add: alu_op = (opcode == rv_isa_pkg::op_reg && alt) ?
					pipe_pkg::alu_sub : pipe_pkg::alu_add;
				rv_isa_pkg::f3_sll: alu_op = pipe_pkg::alu_sll;
				rv_isa_pkg::f3_slt: alu_op = pipe_pkg::alu_slt;
				rv_isa_pkg::f3_sltu: alu_op = pipe_pkg::alu_sltu;
				rv_isa_pkg::f3_xor: alu_op = pipe_pkg::alu_xor;
				rv_isa_pkg::f3_srl: alu_op = alt ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
				rv_isa_pkg::f3_or: alu_op = pipe_pkg::alu_or;
				rv_isa_pkg::f3_and: alu_op = pipe_pkg::alu_and;
				default: alu_op = pipe_pkg::alu_add;
			endcase
		end
	end

	always_comb begin
		dec = '0;
		dec.valid = if_valid;
		dec.pc = if_pc;
		dec.rd = if_instr[11:7];
		dec.rs1 = rd_addr_a;
		dec.rs2 = rd_addr_b;
		dec.rs1_val = rd_data_a;
		dec.rs2_val = rd_data_b;
		dec.alu_op = alu_op;
		case (opcode)
			rv_isa_pkg::op_reg: begin
				dec.write_reg = 1'b1;
			end
			rv_isa_pkg::op_imm: begin
				dec.imm = imm_i;
				dec.use_imm = 1'b1;
				dec.write_reg = 1'b1;
			end
			rv_isa_pkg::op_lui: begin
				dec.imm = imm_u;
				dec.use_imm = 1'b1;
				dec.zero_a = 1'b1;
				dec.write_reg = 1'b1;
			end
			rv_isa_pkg::op_auipc: begin
				dec.imm = imm_u;
				dec.use_imm = 1'b1;
				dec.use_pc = 1'b1;
				dec.write_reg = 1'b1;
			end
			rv_isa_pkg::op_load: begin
				dec.imm = imm_i;
				dec.use_imm = 1'b1;
				dec.write_reg = 1'b1;
				dec.mem_read = 1'b1;
			end
			rv_isa_pkg::op_store: begin
				dec.imm = imm_s;
				dec.use_imm = 1'b1;
				dec.mem_write = 1'b1;
			end
			// Anything else flows through as a no-op
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		id_ex <= dec;
		if (reset) begin
			id_ex.valid <= 1'b0;
		end
	end

	a_fetch_aligned: assert property (
		@(posedge clk) disable iff (reset) fetch_addr[1:0] == 2'b00
	);

endmodule

// File: rtl/execute_memory.sv
`timescale 1ns/10ps

module execute_memory (
	input logic clk,
	input logic reset,
	input pipe_pkg::decoded_t id_ex,
	output rv_isa_pkg::word_t data_addr,
	output rv_isa_pkg::word_t data_wdata,
	output logic data_write,
	output logic data_read,
	input rv_isa_pkg::word_t data_rdata,
	output pipe_pkg::reg_write_t wb_write
);

	rv_isa_pkg::word_t fwd_a;
	rv_isa_pkg::word_t fwd_b;
	rv_isa_pkg::word_t op_a;
	rv_isa_pkg::word_t op_b;
	rv_isa_pkg::word_t alu_result;

	// Memory stage
	logic mem_valid;
	rv_isa_pkg::reg_addr_t mem_rd;
	rv_isa_pkg::word_t mem_result;
	rv_isa_pkg::word_t mem_store_data;
	logic mem_write_reg;
	logic mem_load;
	logic mem_store;
	logic mem_hit;
	rv_isa_pkg::word_t mem_value;

	assign mem_hit = mem_valid && mem_write_reg && (mem_rd != '0);
	// Load data arrives in the same cycle
	assign mem_value = mem_load ? data_rdata : mem_result;

	// Newest producer wins
	function automatic rv_isa_pkg::word_t forward(
		input rv_isa_pkg::reg_addr_t src,
		input rv_isa_pkg::word_t carried
	);
		if (mem_hit && mem_rd == src) begin
			forward = mem_value;
		end else if (wb_write.en && wb_write.rd == src) begin
			forward = wb_write.data;
		end else begin
			forward = carried;
		end
	endfunction

	always_comb begin
		fwd_a = forward(id_ex.rs1, id_ex.rs1_val);
		fwd_b = forward(id_ex.rs2, id_ex.rs2_val);
		if (id_ex.zero_a) begin
			op_a = '0;
		end else if (id_ex.use_pc) begin
			op_a = id_ex.pc;
		end else begin
			op_a = fwd_a;
		end
		op_b = id_ex.use_imm ? id_ex.imm : fwd_b;
	end

	always_comb begin
		case (id_ex.alu_op)
			pipe_pkg::alu_add: alu_result = op_a + op_b;
			pipe_pkg::alu_sub: alu_result = op_a - op_b;
			pipe_pkg::alu_sll: alu_result = op_a << op_b[4:0];
			pipe_pkg::alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			pipe_pkg::alu_sltu: alu_result = {31'b0, op_a < op_b};
			pipe_pkg::alu_xor: alu_result = op_a ^ op_b;
			pipe_pkg::alu_srl: alu_result = op_a >> op_b[4:0];
			pipe_pkg::alu_sra: alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
			pipe_pkg::alu_or: alu_result = op_a | op_b;
			pipe_pkg::alu_and: alu_result = op_a & op_b;
			default: alu_result = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= id_ex.valid;
		end
		mem_rd <= id_ex.rd;
		mem_result <= alu_result;
		mem_store_data <= fwd_b;
		mem_write_reg <= id_ex.write_reg;
		mem_load <= id_ex.mem_read;
		mem_store <= id_ex.mem_write;
	end

	assign data_addr = mem_result;
	assign data_wdata = mem_store_data;
	assign data_write = mem_valid && mem_store;
	assign data_read = mem_valid && mem_load;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_write.en <= 1'b0;
		end else begin
			wb_write.en <= mem_hit;
		end
		wb_write.rd <= mem_rd;
		wb_write.data <= mem_value;
	end

	a_one_strobe: assert property (
		@(posedge clk) disable iff (reset) !(data_read && data_write)
	);

endmodule

// File: rtl/riscv_core.sv
`timescale 1ns/10ps

module riscv_core (
	input logic clk,
	input logic reset,
	output rv_isa_pkg::word_t fetch_addr,
	input rv_isa_pkg::instr_t fetch_instr,
	output rv_isa_pkg::word_t data_addr,
	output rv_isa_pkg::word_t data_wdata,
	output logic data_write,
	output logic data_read,
	input rv_isa_pkg::word_t data_rdata
);

	rv_isa_pkg::reg_addr_t rd_addr_a;
	rv_isa_pkg::reg_addr_t rd_addr_b;
	rv_isa_pkg::word_t rd_data_a;
	rv_isa_pkg::word_t rd_data_b;
	pipe_pkg::decoded_t id_ex;
	pipe_pkg::reg_write_t wb_write;

	fetch_decode fetch_decode_i (
		.clk(clk),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.fetch_instr(fetch_instr),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.id_ex(id_ex)
	);

	register_file register_file_i (
		.clk(clk),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wb_write(wb_write)
	);

	execute_memory execute_memory_i (
		.clk(clk),
		.reset(reset),
		.id_ex(id_ex),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_write(data_write),
		.data_read(data_read),
		.data_rdata(data_rdata),
		.wb_write(wb_write)
	);

endmodule

// File: tb/riscv_core_tb.sv
`timescale 1ns/10ps

module riscv_core_tb;

	logic clk = 1'b0;
	logic reset = 1'b1;
	rv_isa_pkg::word_t fetch_addr;
	rv_isa_pkg::instr_t fetch_instr = rv_isa_pkg::nop_instr;
	rv_isa_pkg::word_t data_addr;
	rv_isa_pkg::word_t data_wdata;
	logic data_write;
	logic data_read;
	rv_isa_pkg::word_t data_rdata = '0;

	integer seed = 53662;
	int cycle = 0;
	int prog_len = 0;
	int first_fetch = -1;
	int first_store = -1;
	int reset_errors = 0;
	int fetch_errors = 0;
	int strobe_errors = 0;
	int passed = 0;
	int failed = 0;
	rv_isa_pkg::word_t fetch_expect = '0;
	rv_isa_pkg::instr_t imem [0:511];
	rv_isa_pkg::instr_t in_flight [0:2] = '{rv_isa_pkg::nop_instr, rv_isa_pkg::nop_instr,
		rv_isa_pkg::nop_instr};
	rv_isa_pkg::word_t dut_mem [rv_isa_pkg::word_t];
	rv_isa_pkg::word_t model_mem [rv_isa_pkg::word_t];
	rv_isa_pkg::word_t model_regs [0:31];
	rv_isa_pkg::word_t exp_addr [$];
	rv_isa_pkg::word_t exp_data [$];
	rv_isa_pkg::word_t act_addr [$];
	rv_isa_pkg::word_t act_data [$];

	riscv_core riscv_core_i (
		.clk(clk),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.fetch_instr(fetch_instr),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_write(data_write),
		.data_read(data_read),
		.data_rdata(data_rdata)
	);

	always #20 clk = ~clk;

	// Data words never stored to
	function automatic rv_isa_pkg::word_t unwritten(input rv_isa_pkg::word_t addr);
		unwritten = addr ^ 32'h5a5a_1234;
	endfunction

	// Memories, reset and checks all move on the falling edge
	always @(negedge clk) begin
		if (reset) begin
			assert (!data_write && !data_read) else begin
				$display("Data strobe high during reset at cycle %0d", cycle);
				reset_errors++;
			end
		end
		if (cycle >= 15) begin
			if (first_fetch < 0 && fetch_addr == '0) begin
				first_fetch = cycle;
			end
			assert (fetch_addr == fetch_expect) else begin
				$display("Fail fetch_sequence: expected %h actual %h", fetch_expect, fetch_addr);
				fetch_errors++;
			end
			fetch_expect = fetch_expect + 32'd4;
			if (data_write) begin
				if (first_store < 0) begin
					first_store = cycle;
				end
				act_addr.push_back(data_addr);
				act_data.push_back(data_wdata);
				dut_mem[data_addr] = data_wdata;
			end
		end
		// Instruction driven three falling edges ago is now in the memory stage
		assert (data_read == (in_flight[2][6:0] == rv_isa_pkg::op_load) &&
			data_write == (in_flight[2][6:0] == rv_isa_pkg::op_store)) else begin
			$display("Fail mem_strobes: expected %b%b actual %b%b at cycle %0d",
				in_flight[2][6:0] == rv_isa_pkg::op_load,
				in_flight[2][6:0] == rv_isa_pkg::op_store, data_read, data_write, cycle);
			strobe_errors++;
		end
		data_rdata = dut_mem.exists(data_addr) ? dut_mem[data_addr] : unwritten(data_addr);
		fetch_instr = (fetch_addr < 4 * prog_len) ? imem[fetch_addr[10:2]] : rv_isa_pkg::nop_instr;
		in_flight[2] = in_flight[1];
		in_flight[1] = in_flight[0];
		in_flight[0] = (cycle >= 15) ? fetch_instr : rv_isa_pkg::nop_instr;
		reset = (cycle < 15);
		cycle++;
	end

	function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
		input rv_isa_pkg::word_t a, input rv_isa_pkg::word_t b);
		case (f3)
			3'b000: alu_ref = alt ? a - b : a + b;
			3'b001: alu_ref = a << b[4:0];
			3'b010: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: alu_ref = (a < b) ? 32'd1 : 32'd0;
			3'b100: alu_ref = a ^ b;
			3'b101: begin
				if (alt) begin
					alu_ref = $signed(a) >>> b[4:0];
				end else begin
					alu_ref = a >> b[4:0];
				end
			end
			3'b110: alu_ref = a | b;
			default: alu_ref = a & b;
		endcase
	endfunction

	// In-order ISA model, one instruction at a time
	task automatic run_model(input rv_isa_pkg::instr_t ins, input rv_isa_pkg::word_t pc);
		rv_isa_pkg::word_t a;
		rv_isa_pkg::word_t b;
		rv_isa_pkg::word_t imm_i;
		rv_isa_pkg::word_t addr;
		rv_isa_pkg::word_t result;
		logic writes;
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		addr = a + imm_i;
		result = '0;
		writes = 1'b1;
		case (ins[6:0])
			rv_isa_pkg::op_reg: result = alu_ref(ins[14:12], ins[30], a, b);
			rv_isa_pkg::op_imm: begin
				result = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
			end
			rv_isa_pkg::op_lui: result = {ins[31:12], 12'b0};
			rv_isa_pkg::op_auipc: result = pc + {ins[31:12], 12'b0};
			rv_isa_pkg::op_load: result = model_mem.exists(addr) ? model_mem[addr] : unwritten(addr);
			rv_isa_pkg::op_store: begin
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				exp_addr.push_back(addr);
				exp_data.push_back(b);
				model_mem[addr] = b;
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && ins[11:7] != 5'd0) begin
			model_regs[ins[11:7]] = result;
		end
	endtask

	task automatic emit(input rv_isa_pkg::instr_t ins);
		run_model(ins, rv_isa_pkg::word_t'(prog_len * 4));
		imem[prog_len] = ins;
		prog_len++;
	endtask

	function automatic rv_isa_pkg::instr_t itype(input logic [11:0] imm,
		input rv_isa_pkg::reg_addr_t rs1, input logic [2:0] f3,
		input rv_isa_pkg::reg_addr_t rd, input logic [6:0] op);
		itype = {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_isa_pkg::instr_t stype(input logic [11:0] imm,
		input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::reg_addr_t rs1);
		stype = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::op_store};
	endfunction

	// Registers x0 to x5 only
	function automatic rv_isa_pkg::reg_addr_t pool_reg(input logic [2:0] bits);
		pool_reg = (bits > 3'd5) ? {2'b00, bits - 3'd2} : {2'b00, bits};
	endfunction

	task automatic emit_random();
		rv_isa_pkg::word_t r;
		rv_isa_pkg::word_t v;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::reg_addr_t rs1;
		rv_isa_pkg::reg_addr_t rs2;
		rv_isa_pkg::reg_addr_t base;
		logic [2:0] f3;
		logic [11:0] imm;
		logic [11:0] offset;
		logic alt;
		r = $random(seed);
		v = $random(seed);
		rd = pool_reg(r[2:0]);
		rs1 = pool_reg(r[5:3]);
		rs2 = pool_reg(r[8:6]);
		f3 = r[11:9];
		imm = v[11:0];
		if (f3 == 3'b001) begin
			imm = {7'b0, v[4:0]};
		end else if (f3 == 3'b101) begin
			imm = {1'b0, v[10], 5'b0, v[4:0]};
		end
		// Half the memory accesses share a small window
		offset = r[12] ? {5'b0, v[4:0], 2'b00} : v[11:0];
		base = r[12] ? 5'd0 : rs1;
		case (r[31:28])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
				alt = r[13] && (f3 == 3'b000 || f3 == 3'b101);
				emit({1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_isa_pkg::op_reg});
			end
			4'd5, 4'd6, 4'd7, 4'd8: emit(itype(imm, rs1, f3, rd, rv_isa_pkg::op_imm));
			4'd9: emit({v[31:12], rd, rv_isa_pkg::op_lui});
			4'd10: emit({v[31:12], rd, rv_isa_pkg::op_auipc});
			4'd11, 4'd12: emit(itype(offset, base, 3'b010, rd, rv_isa_pkg::op_load));
			4'd13, 4'd14: emit(stype(offset, rs2, base));
			default: emit({v[31:7], 7'b0001011});
		endcase
	endtask

	task automatic report(input string name, input int errors);
		if (errors == 0) begin
			$display("Test %s passed", name);
			passed++;
		end else begin
			$display("Test %s failed with %0d errors", name, errors);
			failed++;
		end
	endtask

	initial begin
		int r;
		int i;
		int waited;
		int errors;
		rv_isa_pkg::word_t v;
		for (r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		// Store first, to measure the pipeline depth
		emit(stype(12'h100, 5'd0, 5'd0));
		for (r = 1; r < 32; r++) begin
			v = $random(seed);
			emit({v[31:12], rv_isa_pkg::reg_addr_t'(r), rv_isa_pkg::op_lui});
			emit(itype(v[11:0], rv_isa_pkg::reg_addr_t'(r), 3'b000,
				rv_isa_pkg::reg_addr_t'(r), rv_isa_pkg::op_imm));
		end
		// Dependent chain
		emit(itype(12'h123, 5'd1, 3'b000, 5'd1, rv_isa_pkg::op_imm));
		emit({7'b0000000, 5'd1, 5'd1, 3'b000, 5'd2, rv_isa_pkg::op_reg});
		emit({7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3, rv_isa_pkg::op_reg});
		emit({7'b0100000, 5'd3, 5'd3, 3'b101, 5'd4, rv_isa_pkg::op_reg});
		emit(stype(12'h200, 5'd4, 5'd0));
		// Load used right away
		emit(itype(12'h008, 5'd0, 3'b010, 5'd5, rv_isa_pkg::op_load));
		emit(itype(12'h001, 5'd5, 3'b000, 5'd1, rv_isa_pkg::op_imm));
		emit(stype(12'h204, 5'd5, 5'd0));
		emit(stype(12'h208, 5'd1, 5'd0));
		for (r = 0; r < 300; r++) begin
			emit_random();
		end
		for (r = 0; r < 32; r++) begin
			emit(stype(12'h400 + 12'(r * 4), rv_isa_pkg::reg_addr_t'(r), 5'd0));
		end

		waited = 0;
		while (act_addr.size() < exp_addr.size() && waited < 2000) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		if (act_addr.size() < exp_addr.size()) begin
			$display("Timed out after %0d cycles with %0d of %0d stores seen",
				waited, act_addr.size(), exp_addr.size());
			$display("Some tests failed");
		end else begin
			report("reset_strobes", reset_errors);
			report("fetch_sequence", fetch_errors);
			report("mem_strobes", strobe_errors);
			errors = 0;
			assert (first_store - first_fetch == 3) else begin
				$display("Fail store_latency: expected %0d actual %0d", 3, first_store - first_fetch);
				errors++;
			end
			report("store_latency", errors);
			errors = 0;
			for (i = 0; i < exp_addr.size(); i++) begin
				assert (act_addr[i] == exp_addr[i]) else begin
					$display("Fail store_order: expected %h actual %h at store %0d addr",
						exp_addr[i], act_addr[i], i);
					errors++;
				end
				assert (act_data[i] == exp_data[i]) else begin
					$display("Fail store_order: expected %h actual %h at store %0d data",
						exp_data[i], act_data[i], i);
					errors++;
				end
			end
			report("store_order", errors);
			errors = 0;
			i = exp_addr.size() - 32;
			assert (act_data[i] == 32'h0) else begin
				$display("Fail x0_dump: expected %h actual %h", 32'h0, act_data[i]);
				errors++;
			end
			report("x0_dump", errors);
			$display("Tests: %0d passed, %0d failed", passed, failed);
			if (failed == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
		end
		$finish;
	end

endmodule

// File: project.f
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/register_file.sv
rtl/fetch_decode.sv
rtl/execute_memory.sv
rtl/riscv_core.sv
tb/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert -f project.f --top-module riscv_core_tb -o riscv_core_tb \
	&& ./obj_dir/riscv_core_tb > sim.log 2>&1 \
	; cat sim.log \
	&& grep -q "All tests passed" sim.log \
	|| { echo "Simulation did not pass"; exit 1; }
